// File: axi_read_interconnect.f
+incdir+logic
logic/axi_ic_pkg.sv
logic/ar_port_decoder.sv
logic/axi_reg_slice.sv
logic/rd_crossbar.sv
logic/axi_read_interconnect.sv
tb/ic_checker.sv
tb/tb_axi_read_interconnect.sv

// File: Bender.yml
package:
  name: axi_read_interconnect

sources:
  - include_dirs:
      - logic
    files:
      - logic/axi_ic_pkg.sv
      - logic/ar_port_decoder.sv
      - logic/axi_reg_slice.sv
      - logic/rd_crossbar.sv
      - logic/axi_read_interconnect.sv
  - target: test
    files:
      - tb/ic_checker.sv
      - tb/tb_axi_read_interconnect.sv

// File: tb/ic_trace.txt
# upstream_port id addr len start_delay (all hex, one read request per line)
# data of beat k is (addr + 4k) xor 0x10000000 * (downstream port + 1)
0 1 0100 3 0
1 2 0200 3 0
0 9 8100 2 0
1 a 8200 1 0
0 1 0140 0 1
1 3 0300 7 0
0 a 8400 5 0
0 2 0500 3 0
1 b 8300 0 2
1 c 8310 4 0
0 b 8600 7 0
0 3 0600 1 0
1 4 0400 2 3
1 d 8500 3 0
0 c 8700 0 0
0 4 0700 6 1
1 5 0480 0 0
1 e 8800 5 0
0 d 8900 2 0
0 5 0800 3 0
1 6 0a00 1 0
1 f 8a00 2 1
0 e 8b00 0 0
1 7 0c00 3 0

// File: tb/tb_axi_read_interconnect.sv
`include "axi_ic_consts.svh"

module tb_axi_read_interconnect;

    localparam int S_N        = `AXI_IC_S_COUNT;
    localparam int M_N        = `AXI_IC_M_COUNT;
    localparam int MAX_REQ    = 64;
    localparam int WAIT_LIMIT = 4000;
    localparam int FIFO_D     = 16;

    logic clk;
    logic rst;

    axi_ic_pkg::s_ar_t    s_ar [S_N];
    logic [S_N-1:0]       s_arvalid;
    logic [S_N-1:0]       s_arready;
    axi_ic_pkg::s_r_t     s_r [S_N];
    logic [S_N-1:0]       s_rvalid;
    logic [S_N-1:0]       s_rready;
    axi_ic_pkg::m_ar_t    m_ar [M_N];
    logic [M_N-1:0]       m_arvalid;
    logic [M_N-1:0]       m_arready;
    axi_ic_pkg::m_r_t     m_r [M_N];
    logic [M_N-1:0]       m_rvalid;
    logic [M_N-1:0]       m_rready;

    logic [31:0] lfsr = 32'hee1f2cc8;
    logic        run_failed = 1'b0;
    int          n_req = 0;
    int          tr_port [MAX_REQ];
    int          tr_id [MAX_REQ];
    int          tr_addr [MAX_REQ];
    int          tr_len [MAX_REQ];
    int          tr_delay [MAX_REQ];

    // downstream memory model request queues
    axi_ic_pkg::addr_t mq_addr [M_N][FIFO_D];
    axi_ic_pkg::m_id_t mq_id [M_N][FIFO_D];
    axi_ic_pkg::len_t  mq_len [M_N][FIFO_D];
    int                mq_wr [M_N] = '{default: 0};
    int                mq_rd [M_N] = '{default: 0};
    int                mq_cnt [M_N] = '{default: 0};
    int                mq_beat [M_N] = '{default: 0};

    axi_read_interconnect u_dut (.*);

    ic_checker #(.MAX_REQ(MAX_REQ)) u_chk (.*);

    function automatic logic next_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) lfsr = lfsr ^ 32'h8020_0003;
        return b;
    endfunction

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin : mem_model
        logic fired [M_N];
        int   h;
        logic in_rst;
        in_rst = rst;
        for (int m = 0; m < M_N; m++) begin
            fired[m] = 1'b0;
            if (!rst && m_arvalid[m] && m_arready[m]) begin
                mq_addr[m][mq_wr[m]] = m_ar[m].addr;
                mq_id[m][mq_wr[m]]   = m_ar[m].id;
                mq_len[m][mq_wr[m]]  = m_ar[m].len;
                mq_wr[m]             = (mq_wr[m] + 1) % FIFO_D;
                mq_cnt[m]++;
            end
            if (!rst && m_rvalid[m] && m_rready[m]) begin
                fired[m] = 1'b1;
                if (mq_beat[m] == int'(mq_len[m][mq_rd[m]])) begin
                    mq_rd[m]   = (mq_rd[m] + 1) % FIFO_D;
                    mq_beat[m] = 0;
                    mq_cnt[m]--;
                end else begin
                    mq_beat[m]++;
                end
            end
        end
        #1;
        for (int m = 0; m < M_N; m++) begin
            if (in_rst) begin
                m_arready[m] = 1'b0;
                m_rvalid[m]  = 1'b0;
            end else begin
                m_arready[m] = (mq_cnt[m] < FIFO_D - 2) && next_bit();
                if (fired[m] || !m_rvalid[m]) begin
                    h           = mq_rd[m];
                    m_rvalid[m] = (mq_cnt[m] > 0) && next_bit();
                    m_r[m].id   = mq_id[m][h];
                    m_r[m].data = ({16'h0, mq_addr[m][h]} + 32'(4 * mq_beat[m]))
                                  ^ (32'h1000_0000 * (m + 1));
                    m_r[m].resp = 2'b00;
                    m_r[m].last = mq_beat[m] == int'(mq_len[m][h]);
                end
            end
        end
        for (int s = 0; s < S_N; s++) begin
            s_rready[s] = !in_rst && (next_bit() || next_bit());
        end
    end

    task automatic load_trace();
        int    fd;
        string line;
        fd = $fopen("tb/ic_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file tb/ic_trace.txt");
            run_failed = 1'b1;
            return;
        end
        while (!$feof(fd) && n_req < MAX_REQ) begin
            if ($fgets(line, fd) == 0) break;
            if (line.len() == 0 || line[0] == "#") continue;
            if ($sscanf(line, "%h %h %h %h %h", tr_port[n_req], tr_id[n_req], tr_addr[n_req],
                        tr_len[n_req], tr_delay[n_req]) == 5) begin
                n_req++;
            end
        end
        $fclose(fd);
    endtask

    // one upstream port walks its share of the trace in order
    task automatic issue_requests(input int p);
        int   waited;
        logic done;
        for (int i = 0; i < n_req && !run_failed; i++) begin
            if (tr_port[i] != p) continue;
            if (tr_delay[i] > 0) begin
                repeat (tr_delay[i]) @(posedge clk);
                #1;
            end
            s_ar[p].id   = axi_ic_pkg::s_id_t'(tr_id[i]);
            s_ar[p].addr = axi_ic_pkg::addr_t'(tr_addr[i]);
            s_ar[p].len  = axi_ic_pkg::len_t'(tr_len[i]);
            s_arvalid[p] = 1'b1;
            u_chk.add_request(p, s_ar[p].id, s_ar[p].addr, s_ar[p].len);
            waited = 0;
            done   = 1'b0;
            while (!done && waited < WAIT_LIMIT) begin
                @(posedge clk);
                done = s_arready[p];
                waited++;
            end
            #1;
            s_arvalid[p] = 1'b0;
            if (!done) begin
                $display("upstream port %0d timed out waiting for arready", p);
                run_failed = 1'b1;
            end
        end
    endtask

    initial begin : main
        int waited;
        int exp_beats;
        rst       = 1'b1;
        s_arvalid = '0;
        s_rready  = '0;
        m_arready = '0;
        m_rvalid  = '0;
        for (int s = 0; s < S_N; s++) s_ar[s] = '0;
        for (int m = 0; m < M_N; m++) m_r[m] = '0;
        load_trace();
        if (n_req == 0 && !run_failed) begin
            $display("the trace file holds no requests");
            run_failed = 1'b1;
        end
        // each request returns len+1 beats
        exp_beats = 0;
        for (int i = 0; i < n_req; i++) begin
            exp_beats += tr_len[i] + 1;
        end
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        if (!run_failed) begin
            fork
                issue_requests(0);
                issue_requests(1);
            join
        end
        waited = 0;
        while (!run_failed && u_chk.bursts_done < n_req && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!run_failed && u_chk.bursts_done < n_req) begin
            $display("timed out waiting for all read bursts to return");
            run_failed = 1'b1;
        end
        @(posedge clk);
        #1;
        if (u_chk.ar_seen != n_req) begin
            $display("downstream saw %0d requests where %0d were issued", u_chk.ar_seen, n_req);
            run_failed = 1'b1;
        end
        if (u_chk.beats != exp_beats) begin
            $display("upstream saw %0d read beats where %0d were expected",
                     u_chk.beats, exp_beats);
            run_failed = 1'b1;
        end
        $display("requests %0d, downstream requests %0d, bursts %0d, beats %0d of %0d, errors %0d",
                 n_req, u_chk.ar_seen, u_chk.bursts_done, u_chk.beats, exp_beats, u_chk.errors);
        if (run_failed || u_chk.errors > 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST OK");
        end
        $finish;
    end

endmodule

// File: tb/ic_checker.sv
`include "axi_ic_consts.svh"

module ic_checker #(
    parameter int MAX_REQ = 64
) (
    input logic                       clk,
    input logic                       rst,
    input axi_ic_pkg::s_ar_t          s_ar [`AXI_IC_S_COUNT],
    input logic [`AXI_IC_S_COUNT-1:0] s_arvalid,
    input logic [`AXI_IC_S_COUNT-1:0] s_arready,
    input axi_ic_pkg::s_r_t           s_r [`AXI_IC_S_COUNT],
    input logic [`AXI_IC_S_COUNT-1:0] s_rvalid,
    input logic [`AXI_IC_S_COUNT-1:0] s_rready,
    input axi_ic_pkg::m_ar_t          m_ar [`AXI_IC_M_COUNT],
    input logic [`AXI_IC_M_COUNT-1:0] m_arvalid,
    input logic [`AXI_IC_M_COUNT-1:0] m_arready
);

    localparam int S_N = `AXI_IC_S_COUNT;
    localparam int M_N = `AXI_IC_M_COUNT;

    int errors = 0;
    int beats = 0;
    int bursts_done = 0;
    int ar_seen = 0;
    int n_exp = 0;
    int rst_cycles = 0;
    logic reset_reported = 1'b0;

    int                e_port [MAX_REQ];
    axi_ic_pkg::s_id_t e_id   [MAX_REQ];
    axi_ic_pkg::addr_t e_addr [MAX_REQ];
    axi_ic_pkg::len_t  e_len  [MAX_REQ];
    logic              e_used [MAX_REQ];
    logic              e_ar   [MAX_REQ];

    int   cur_idx    [S_N];
    int   cur_beat   [S_N];
    int   err_start  [S_N];
    logic cur_active [S_N] = '{default: 1'b0};

    // accepted upstream requests not yet granted downstream, by target
    axi_ic_pkg::port_t acc_tgt [S_N][MAX_REQ];
    int                acc_wr  [S_N] = '{default: 0};
    int                acc_rd  [S_N] = '{default: 0};
    int                rr_ptr  [M_N] = '{default: 0};
    logic              stalled [M_N] = '{default: 1'b0};

    task automatic add_request(input int port, input axi_ic_pkg::s_id_t id,
                               input axi_ic_pkg::addr_t addr, input axi_ic_pkg::len_t len);
        e_port[n_exp] = port;
        e_id[n_exp]   = id;
        e_addr[n_exp] = addr;
        e_len[n_exp]  = len;
        e_used[n_exp] = 1'b0;
        e_ar[n_exp]   = 1'b0;
        n_exp++;
    endtask

    task automatic value_error(input string name, input int port,
                               input logic [31:0] got, input logic [31:0] expd);
        $display("CHECK FAILED %s port %0d got %h expected %h", name, port, got, expd);
        errors++;
    endtask

    // memory rule: address plus beat offset, tagged by the downstream port
    function automatic axi_ic_pkg::data_t beat_data(input axi_ic_pkg::addr_t addr, input int k);
        axi_ic_pkg::data_t tag;
        tag = 32'h1000_0000 * (int'(addr[`AXI_IC_ADDR_W-1]) + 1);
        return ({16'h0, addr} + axi_ic_pkg::data_t'(4 * k)) ^ tag;
    endfunction

    // oldest open request of this port and id
    function automatic int find_burst(input int port, input axi_ic_pkg::s_id_t id);
        for (int i = 0; i < n_exp; i++) begin
            if (e_port[i] == port && e_id[i] == id && !e_used[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    // reset state of all valid outputs
    always @(posedge clk) begin
        if (rst) begin
            rst_cycles++;
        end
        if ((rst && rst_cycles > 1) || (!rst && rst_cycles > 0 && !reset_reported)) begin
            if (m_arvalid !== '0) value_error("m_arvalid", 0, 32'(m_arvalid), 0);
            if (s_rvalid !== '0) value_error("s_rvalid", 0, 32'(s_rvalid), 0);
        end
        if (!rst && rst_cycles > 0 && !reset_reported) begin
            reset_reported = 1'b1;
            $display("test reset state: %s", errors == 0 ? "ok" : "failed");
        end
    end

    // downstream requests: decode and id extension
    always @(posedge clk) begin : ar_watch
        int idx;
        for (int m = 0; m < M_N; m++) begin
            if (!rst && m_arvalid[m] && m_arready[m]) begin
                ar_seen++;
                idx = -1;
                for (int i = 0; i < n_exp && idx < 0; i++) begin
                    if (!e_ar[i] && e_addr[i] == m_ar[m].addr && e_len[i] == m_ar[m].len
                        && {1'(e_port[i]), e_id[i]} == m_ar[m].id) begin
                        idx = i;
                    end
                end
                if (idx < 0) begin
                    $display("downstream port %0d saw a request that was never issued", m);
                    errors++;
                end else begin
                    e_ar[idx] = 1'b1;
                end
                if (m_ar[m].addr[`AXI_IC_ADDR_W-1] !== 1'(m)) begin
                    value_error("m_ar.addr[15]", m, 32'(m_ar[m].addr[`AXI_IC_ADDR_W-1]), 32'(m));
                end
            end
        end
    end

    // a fresh grant with both heads waiting goes to the pointer port
    always @(posedge clk) begin : arb_watch
        axi_ic_pkg::port_t win;
        logic              both;
        for (int m = 0; m < M_N; m++) begin
            if (!rst && m_arvalid[m] && !stalled[m]) begin
                both = 1'b1;
                for (int s = 0; s < S_N; s++) begin
                    if (acc_rd[s] >= acc_wr[s]
                        || acc_tgt[s][acc_rd[s]] != axi_ic_pkg::port_t'(m)) begin
                        both = 1'b0;
                    end
                end
                win = m_ar[m].id[`AXI_IC_M_ID_W-1 -: `AXI_IC_PORT_W];
                if (both && int'(win) != rr_ptr[m]) begin
                    value_error("m_ar.id source", m, 32'(win), 32'(rr_ptr[m]));
                end
            end
        end
        for (int m = 0; m < M_N; m++) begin
            if (!rst && m_arvalid[m] && m_arready[m]) begin
                win         = m_ar[m].id[`AXI_IC_M_ID_W-1 -: `AXI_IC_PORT_W];
                rr_ptr[m]   = (int'(win) + 1) % S_N;
                stalled[m]  = 1'b0;
                acc_rd[win] = acc_rd[win] + 1;
            end else if (!rst && m_arvalid[m]) begin
                stalled[m] = 1'b1;
            end
        end
        for (int s = 0; s < S_N; s++) begin
            if (!rst && s_arvalid[s] && s_arready[s] && acc_wr[s] < MAX_REQ) begin
                acc_tgt[s][acc_wr[s]] = s_ar[s].addr[`AXI_IC_ADDR_W-1 -: `AXI_IC_PORT_W];
                acc_wr[s]             = acc_wr[s] + 1;
            end
        end
    end

    // upstream beats: whole bursts, data rule, last flag
    always @(posedge clk) begin : r_watch
        int idx;
        for (int s = 0; s < S_N; s++) begin
            if (rst || !(s_rvalid[s] && s_rready[s])) continue;
            beats++;
            if (!cur_active[s]) begin
                idx = find_burst(s, s_r[s].id);
                if (idx < 0) begin
                    $display("upstream port %0d got a burst with unknown id %h", s, s_r[s].id);
                    errors++;
                    continue;
                end
                cur_idx[s]    = idx;
                cur_beat[s]   = 0;
                err_start[s]  = errors;
                cur_active[s] = 1'b1;
                e_used[idx]   = 1'b1;
            end
            idx = cur_idx[s];
            if (s_r[s].id !== e_id[idx]) value_error("s_r.id", s, 32'(s_r[s].id), 32'(e_id[idx]));
            if (s_r[s].data !== beat_data(e_addr[idx], cur_beat[s])) begin
                value_error("s_r.data", s, s_r[s].data, beat_data(e_addr[idx], cur_beat[s]));
            end
            if (s_r[s].resp !== 2'b00) value_error("s_r.resp", s, 32'(s_r[s].resp), 0);
            if (s_r[s].last !== (cur_beat[s] == int'(e_len[idx]))) begin
                value_error("s_r.last", s, 32'(s_r[s].last), 32'(cur_beat[s] == int'(e_len[idx])));
            end
            if (s_r[s].last || cur_beat[s] == int'(e_len[idx])) begin
                cur_active[s] = 1'b0;
                bursts_done++;
                $display("test %0d port %0d id %h addr %h len %0d: %s", idx, s, e_id[idx],
                         e_addr[idx], e_len[idx], errors > err_start[s] ? "failed" : "ok");
            end else begin
                cur_beat[s]++;
            end
        end
    end

endmodule

// File: logic/axi_read_interconnect.sv
`include "axi_ic_consts.svh"

module axi_read_interconnect (
    input  logic                       clk,
    input  logic                       rst,
    input  axi_ic_pkg::s_ar_t          s_ar [`AXI_IC_S_COUNT],
    input  logic [`AXI_IC_S_COUNT-1:0] s_arvalid,
    output logic [`AXI_IC_S_COUNT-1:0] s_arready,
    output axi_ic_pkg::s_r_t           s_r [`AXI_IC_S_COUNT],
    output logic [`AXI_IC_S_COUNT-1:0] s_rvalid,
    input  logic [`AXI_IC_S_COUNT-1:0] s_rready,
    output axi_ic_pkg::m_ar_t          m_ar [`AXI_IC_M_COUNT],
    output logic [`AXI_IC_M_COUNT-1:0] m_arvalid,
    input  logic [`AXI_IC_M_COUNT-1:0] m_arready,
    input  axi_ic_pkg::m_r_t           m_r [`AXI_IC_M_COUNT],
    input  logic [`AXI_IC_M_COUNT-1:0] m_rvalid,
    output logic [`AXI_IC_M_COUNT-1:0] m_rready
);

    localparam int AR_W      = $bits(axi_ic_pkg::m_ar_t);
    localparam int AR_ITEM_W = AR_W + $bits(axi_ic_pkg::port_t);
    localparam int R_ITEM_W  = $bits(axi_ic_pkg::m_r_t);

    axi_ic_pkg::m_ar_t          dec_ar  [`AXI_IC_S_COUNT];
    axi_ic_pkg::port_t          dec_tgt [`AXI_IC_S_COUNT];
    logic [AR_ITEM_W-1:0]       sl_ar   [`AXI_IC_S_COUNT];
    axi_ic_pkg::m_ar_t          xb_ar   [`AXI_IC_S_COUNT];
    axi_ic_pkg::port_t          xb_tgt  [`AXI_IC_S_COUNT];
    logic [`AXI_IC_S_COUNT-1:0] xb_ar_valid;
    logic [`AXI_IC_S_COUNT-1:0] xb_ar_ready;
    axi_ic_pkg::m_r_t           xb_r    [`AXI_IC_M_COUNT];
    logic [`AXI_IC_M_COUNT-1:0] xb_r_valid;
    logic [`AXI_IC_M_COUNT-1:0] xb_r_ready;

    // upstream side: decode then register the request
    for (genvar s = 0; s < `AXI_IC_S_COUNT; s++) begin : g_up
        ar_port_decoder #(
            .PORT_INDEX(s)
        ) u_dec (
            .s_ar   (s_ar[s]),
            .m_ar   (dec_ar[s]),
            .target (dec_tgt[s])
        );

        // target travels with the request through the slice
        axi_reg_slice #(
            .WIDTH(AR_ITEM_W)
        ) u_ar_slice (
            .clk       (clk),
            .rst       (rst),
            .in_data   ({dec_tgt[s], dec_ar[s]}),
            .in_valid  (s_arvalid[s]),
            .in_ready  (s_arready[s]),
            .out_data  (sl_ar[s]),
            .out_valid (xb_ar_valid[s]),
            .out_ready (xb_ar_ready[s])
        );

        assign xb_tgt[s] = sl_ar[s][AR_ITEM_W-1:AR_W];
        assign xb_ar[s]  = sl_ar[s][AR_W-1:0];
    end

    // downstream side: register returning beats
    for (genvar m = 0; m < `AXI_IC_M_COUNT; m++) begin : g_dn
        axi_reg_slice #(
            .WIDTH(R_ITEM_W)
        ) u_r_slice (
            .clk       (clk),
            .rst       (rst),
            .in_data   (m_r[m]),
            .in_valid  (m_rvalid[m]),
            .in_ready  (m_rready[m]),
            .out_data  (xb_r[m]),
            .out_valid (xb_r_valid[m]),
            .out_ready (xb_r_ready[m])
        );
    end

    rd_crossbar u_xbar (
        .clk         (clk),
        .rst         (rst),
        .ar_in       (xb_ar),
        .ar_tgt      (xb_tgt),
        .ar_in_valid (xb_ar_valid),
        .ar_in_ready (xb_ar_ready),
        .m_ar        (m_ar),
        .m_arvalid   (m_arvalid),
        .m_arready   (m_arready),
        .r_in        (xb_r),
        .r_in_valid  (xb_r_valid),
        .r_in_ready  (xb_r_ready),
        .s_r         (s_r),
        .s_rvalid    (s_rvalid),
        .s_rready    (s_rready)
    );

endmodule

// File: logic/rd_crossbar.sv
`include "axi_ic_consts.svh"

module rd_crossbar (
    input  logic                       clk,
    input  logic                       rst,
    input  axi_ic_pkg::m_ar_t          ar_in [`AXI_IC_S_COUNT],
    input  axi_ic_pkg::port_t          ar_tgt [`AXI_IC_S_COUNT],
    input  logic [`AXI_IC_S_COUNT-1:0] ar_in_valid,
    output logic [`AXI_IC_S_COUNT-1:0] ar_in_ready,
    output axi_ic_pkg::m_ar_t          m_ar [`AXI_IC_M_COUNT],
    output logic [`AXI_IC_M_COUNT-1:0] m_arvalid,
    input  logic [`AXI_IC_M_COUNT-1:0] m_arready,
    input  axi_ic_pkg::m_r_t           r_in [`AXI_IC_M_COUNT],
    input  logic [`AXI_IC_M_COUNT-1:0] r_in_valid,
    output logic [`AXI_IC_M_COUNT-1:0] r_in_ready,
    output axi_ic_pkg::s_r_t           s_r [`AXI_IC_S_COUNT],
    output logic [`AXI_IC_S_COUNT-1:0] s_rvalid,
    input  logic [`AXI_IC_S_COUNT-1:0] s_rready
);

    localparam int S_N = `AXI_IC_S_COUNT;
    localparam int M_N = `AXI_IC_M_COUNT;

    axi_ic_pkg::port_t ar_sel [M_N];
    axi_ic_pkg::port_t r_sel  [S_N];
    axi_ic_pkg::port_t r_dst  [M_N];

    // read address, one arbiter per downstream port
    for (genvar m = 0; m < M_N; m++) begin : g_ar
        axi_ic_pkg::port_t ptr;
        axi_ic_pkg::port_t held;
        axi_ic_pkg::port_t pick;
        axi_ic_pkg::port_t cand;
        logic              hold;
        logic              found;

        always_comb begin
            pick  = ptr;
            found = 1'b0;
            for (int i = 0; i < S_N; i++) begin
                cand = axi_ic_pkg::port_t'((int'(ptr) + i) % S_N);
                if (!found && ar_in_valid[cand] && ar_tgt[cand] == axi_ic_pkg::port_t'(m)) begin
                    pick  = cand;
                    found = 1'b1;
                end
            end
        end

        // stalled grant stays put until it transfers
        assign ar_sel[m]    = hold ? held : pick;
        assign m_arvalid[m] = ar_in_valid[ar_sel[m]]
                              && ar_tgt[ar_sel[m]] == axi_ic_pkg::port_t'(m);
        assign m_ar[m]      = ar_in[ar_sel[m]];

        always_ff @(posedge clk) begin
            if (rst) begin
                ptr  <= '0;
                hold <= 1'b0;
            end else if (m_arvalid[m] && m_arready[m]) begin
                ptr  <= axi_ic_pkg::port_t'((int'(ar_sel[m]) + 1) % S_N);
                hold <= 1'b0;
            end else if (m_arvalid[m]) begin
                hold <= 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (m_arvalid[m] && !m_arready[m]) begin
                held <= ar_sel[m];
            end
        end
    end

    always_comb begin
        for (int s = 0; s < S_N; s++) begin
            ar_in_ready[s] = m_arvalid[ar_tgt[s]] && m_arready[ar_tgt[s]]
                             && ar_sel[ar_tgt[s]] == axi_ic_pkg::port_t'(s);
        end
    end

    // source index sits in the top id bits
    for (genvar m = 0; m < M_N; m++) begin : g_dst
        assign r_dst[m] = r_in[m].id[`AXI_IC_M_ID_W-1 -: `AXI_IC_PORT_W];
    end

    // read data return, one lock per upstream port
    for (genvar s = 0; s < S_N; s++) begin : g_ret
        axi_ic_pkg::ret_state_e state;
        axi_ic_pkg::port_t      src;
        axi_ic_pkg::port_t      pick;
        axi_ic_pkg::port_t      cand;
        axi_ic_pkg::m_r_t       beat;
        logic                   found;
        logic                   fire;

        // idle search starts after the port served last
        always_comb begin
            pick  = src;
            found = 1'b0;
            for (int i = 1; i <= M_N; i++) begin
                cand = axi_ic_pkg::port_t'((int'(src) + i) % M_N);
                if (!found && r_in_valid[cand] && r_dst[cand] == axi_ic_pkg::port_t'(s)) begin
                    pick  = cand;
                    found = 1'b1;
                end
            end
        end

        assign r_sel[s]    = (state == axi_ic_pkg::ret_locked) ? src : pick;
        assign beat        = r_in[r_sel[s]];
        assign s_rvalid[s] = r_in_valid[r_sel[s]] && r_dst[r_sel[s]] == axi_ic_pkg::port_t'(s);
        assign fire        = s_rvalid[s] && s_rready[s];

        // drop the source bits on the way back
        assign s_r[s] = '{beat.id[`AXI_IC_S_ID_W-1:0], beat.data, beat.resp, beat.last};

        always_ff @(posedge clk) begin
            if (rst) begin
                state <= axi_ic_pkg::ret_idle;
                src   <= '0;
            end else begin
                case (state)
                    axi_ic_pkg::ret_idle: begin
                        if (s_rvalid[s]) begin
                            src <= r_sel[s];
                        end
                        // single-beat burst needs no lock
                        if (s_rvalid[s] && !(fire && beat.last)) begin
                            state <= axi_ic_pkg::ret_locked;
                        end
                    end
                    axi_ic_pkg::ret_locked: begin
                        if (fire && beat.last) begin
                            state <= axi_ic_pkg::ret_idle;
                        end
                    end
                    default: state <= axi_ic_pkg::ret_idle;
                endcase
            end
        end
    end

    always_comb begin
        for (int m = 0; m < M_N; m++) begin
            r_in_ready[m] = s_rready[r_dst[m]] && r_sel[r_dst[m]] == axi_ic_pkg::port_t'(m);
        end
    end

endmodule

// File: logic/axi_reg_slice.sv
module axi_reg_slice #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] in_data,
    input  logic             in_valid,
    output logic             in_ready,
    output logic [WIDTH-1:0] out_data,
    output logic             out_valid,
    input  logic             out_ready
);

    logic [WIDTH-1:0] skid_data;
    logic             skid_valid;
    logic             in_fire;
    logic             out_free;

    // accept while the skid entry is empty
    assign in_ready = !skid_valid;
    assign in_fire  = in_valid && in_ready;

    // main entry drains or is empty this cycle
    assign out_free = out_ready || !out_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_free) begin
            // skid entry goes first to keep order
            out_valid  <= skid_valid || in_fire;
            skid_valid <= 1'b0;
        end else if (in_fire) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            out_data <= skid_valid ? skid_data : in_data;
        end
        if (!out_free && in_fire) begin
            skid_data <= in_data;
        end
    end

endmodule

// File: logic/ar_port_decoder.sv
`include "axi_ic_consts.svh"

module ar_port_decoder #(
    parameter int PORT_INDEX = 0
) (
    input  axi_ic_pkg::s_ar_t s_ar,
    output axi_ic_pkg::m_ar_t m_ar,
    output axi_ic_pkg::port_t target
);

    axi_ic_pkg::port_t src_idx;

    assign src_idx = axi_ic_pkg::port_t'(PORT_INDEX);

    // source index lands above the upstream id
    assign m_ar.id = {src_idx, s_ar.id};

    // address and length go through untouched
    assign m_ar.addr = s_ar.addr;
    assign m_ar.len  = s_ar.len;

    // top address bits pick the downstream port
    assign target = s_ar.addr[`AXI_IC_ADDR_W-1 -: `AXI_IC_PORT_W];

endmodule

// File: logic/axi_ic_pkg.sv
`include "axi_ic_consts.svh"

package axi_ic_pkg;

    typedef logic [`AXI_IC_ADDR_W-1:0] addr_t;
    typedef logic [`AXI_IC_DATA_W-1:0] data_t;
    typedef logic [`AXI_IC_S_ID_W-1:0] s_id_t;
    typedef logic [`AXI_IC_M_ID_W-1:0] m_id_t;
    typedef logic [`AXI_IC_LEN_W-1:0]  len_t;
    typedef logic [`AXI_IC_PORT_W-1:0] port_t;
    typedef logic [`AXI_IC_RESP_W-1:0] resp_t;

    typedef struct packed {
        s_id_t id;
        addr_t addr;
        len_t  len;
    } s_ar_t;

    typedef struct packed {
        m_id_t id;
        addr_t addr;
        len_t  len;
    } m_ar_t;

    typedef struct packed {
        m_id_t id;
        data_t data;
        resp_t resp;
        logic  last;
    } m_r_t;

    typedef struct packed {
        s_id_t id;
        data_t data;
        resp_t resp;
        logic  last;
    } s_r_t;

    // per upstream port, held from first beat to rlast
    typedef enum logic [0:0] {
        ret_idle,
        ret_locked
    } ret_state_e;

endpackage

// File: logic/axi_ic_consts.svh
`ifndef AXI_IC_CONSTS_SVH
`define AXI_IC_CONSTS_SVH

// port counts
`define AXI_IC_S_COUNT 2
`define AXI_IC_M_COUNT 2

// field widths
`define AXI_IC_ADDR_W 16
`define AXI_IC_DATA_W 32
`define AXI_IC_LEN_W 8
`define AXI_IC_RESP_W 2

// wide enough for either port count
`define AXI_IC_PORT_W 1

// upstream id
`define AXI_IC_S_ID_W 4

// downstream id carries the source index on top
`define AXI_IC_M_ID_W (`AXI_IC_S_ID_W + `AXI_IC_PORT_W)

`endif
